/* common/dlfloat_pkg.sv */
`default_nettype none

package dlfloat_pkg;

   // DLFloat16 is 1 sign, 6 exponent and 9 mantissa bits
   localparam int DL_WIDTH   = 16;
   localparam int EXP_WIDTH  = 6;
   localparam int MANT_WIDTH = 9;
   localparam int GRS_WIDTH  = 4;                      // guard, round, two sticky
   localparam int EXT_WIDTH  = DL_WIDTH + GRS_WIDTH;
   localparam int EXP_BIAS   = 31;
   localparam int EXP_MAX    = 2**EXP_WIDTH - 1;

   typedef logic [DL_WIDTH-1:0]  dl_float_t;
   typedef logic [EXT_WIDTH-1:0] dl_ext_t;

   // msb first, same order as the flag ports
   typedef struct packed {
      logic invalid;
      logic inexact;
      logic overflow;
      logic underflow;
      logic div_by_zero;
   } dl_flags_t;

   typedef logic [3:0] op_code_t;
   localparam op_code_t OP_ADD_SUB = 4'b0001;
   localparam op_code_t OP_MUL     = 4'b0010;
   localparam op_code_t OP_SIGN    = 4'b0101;
   localparam op_code_t OP_CMP     = 4'b0110;

   typedef logic [2:0] rnd_mode_t;
   localparam rnd_mode_t RM_NEAREST_EVEN = 3'b000;
   localparam rnd_mode_t RM_TO_ZERO      = 3'b001;
   localparam rnd_mode_t RM_UP           = 3'b010;
   localparam rnd_mode_t RM_DOWN         = 3'b011;

   typedef logic [2:0] cmp_sel_t;
   localparam cmp_sel_t CMP_MIN = 3'b001;
   localparam cmp_sel_t CMP_MAX = 3'b010;
   localparam cmp_sel_t CMP_EQ  = 3'b011;
   localparam cmp_sel_t CMP_LT  = 3'b100;
   localparam cmp_sel_t CMP_LE  = 3'b101;

   typedef logic [1:0] sign_sel_t;
   localparam sign_sel_t SIGN_NEG = 2'b00;             // inverted sign of a
   localparam sign_sel_t SIGN_INJ = 2'b01;
   localparam sign_sel_t SIGN_INV = 2'b10;
   localparam sign_sel_t SIGN_XOR = 2'b11;

   localparam dl_float_t DL_MAX_POS = 16'h7DFE;
   localparam dl_float_t DL_MAX_NEG = 16'hFDFE;
   localparam dl_float_t DL_MIN_POS = 16'h0201;
   localparam dl_float_t DL_MIN_NEG = 16'h8201;
   localparam dl_float_t DL_NAN     = 16'hFFFF;

endpackage

`default_nettype wire

/* add_sub/dlfloat_align.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_align import dlfloat_pkg::*; (
   input  dl_float_t             a,
   input  dl_float_t             b,
   input  logic                  op,
   output logic [MANT_WIDTH:0]   large_mant,
   output logic [MANT_WIDTH:0]   small_mant,
   output logic [EXP_WIDTH-1:0]  large_exp,
   output logic                  eff_sub,
   output logic                  res_sign
);

   logic                 sign_a;
   logic                 sign_b;              // after the subtract flip
   logic [EXP_WIDTH-1:0] exp_a;
   logic [EXP_WIDTH-1:0] exp_b;
   logic [EXP_WIDTH-1:0] shift;
   logic [MANT_WIDTH:0]  small_raw;

   assign sign_a  = a[DL_WIDTH-1];
   assign sign_b  = b[DL_WIDTH-1] ^ op;
   assign exp_a   = a[DL_WIDTH-2 -: EXP_WIDTH];
   assign exp_b   = b[DL_WIDTH-2 -: EXP_WIDTH];
   assign eff_sub = sign_a ^ sign_b;

   always_comb begin
      if (exp_a > exp_b) begin
         large_exp  = exp_a;
         large_mant = {1'b1, a[MANT_WIDTH-1:0]};
         small_raw  = {1'b1, b[MANT_WIDTH-1:0]};
         shift      = exp_a - exp_b;
      end else begin
         large_exp  = exp_b;
         large_mant = {1'b1, b[MANT_WIDTH-1:0]};
         small_raw  = {1'b1, a[MANT_WIDTH-1:0]};
         shift      = exp_b - exp_a;
      end
      // zero exponent keeps the small side at the bare hidden bit
      if (exp_a == '0 || exp_b == '0)
         small_mant = {1'b1, {MANT_WIDTH{1'b0}}};
      else
         small_mant = small_raw >> shift;
   end

   // signs first, then exponents, then mantissas
   always_comb begin
      if (!eff_sub)
         res_sign = sign_a;
      else if (exp_a > exp_b)
         res_sign = sign_a;
      else if (exp_b > exp_a)
         res_sign = sign_b;
      else if (a[MANT_WIDTH-1:0] > b[MANT_WIDTH-1:0])
         res_sign = sign_a;
      else if (a[MANT_WIDTH-1:0] < b[MANT_WIDTH-1:0])
         res_sign = sign_b;
      else
         res_sign = 1'b0;                     // exact cancel gives plus
   end

endmodule

`default_nettype wire

/* add_sub/dlfloat_add_sub.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_add_sub import dlfloat_pkg::*; (
   input  dl_float_t  a,
   input  dl_float_t  b,
   input  logic       op,
   output dl_ext_t    sum,
   output dl_flags_t  flags
);

   logic [MANT_WIDTH:0]   large_mant;
   logic [MANT_WIDTH:0]   small_mant;
   logic [MANT_WIDTH:0]   big;
   logic [MANT_WIDTH:0]   little;
   logic [EXP_WIDTH-1:0]  large_exp;
   logic [EXP_WIDTH-1:0]  res_exp;
   logic                  eff_sub;
   logic                  res_sign;
   logic                  no_add;
   logic [MANT_WIDTH+1:0] raw_sum;          // one carry bit on top
   logic                  carry;
   logic [MANT_WIDTH:0]   norm;
   logic [3:0]            lz;
   logic [MANT_WIDTH-1:0] res_mant;
   logic [GRS_WIDTH-1:0]  res_grs;

   dlfloat_align align_inst (
      .a          (a),
      .b          (b),
      .op         (op),
      .large_mant (large_mant),
      .small_mant (small_mant),
      .large_exp  (large_exp),
      .eff_sub    (eff_sub),
      .res_sign   (res_sign)
   );

   // equal exponents can leave the shifted side bigger
   assign big    = (small_mant < large_mant) ? large_mant : small_mant;
   assign little = (small_mant < large_mant) ? small_mant : large_mant;
   assign no_add = (a[DL_WIDTH-2 -: EXP_WIDTH] == '0) || (b[DL_WIDTH-2 -: EXP_WIDTH] == '0);
   assign carry  = raw_sum[MANT_WIDTH+1];

   always_comb begin
      if (no_add)
         raw_sum = {1'b0, big};
      else if (eff_sub)
         raw_sum = {1'b0, big} - {1'b0, little};
      else
         raw_sum = {1'b0, big} + {1'b0, little};
   end

   // leading zeros below the hidden bit position
   always_comb begin
      lz = '0;
      for (int i = 0; i <= MANT_WIDTH; i++) begin
         if (raw_sum[i])
            lz = 4'(MANT_WIDTH - i);
      end
   end

   always_comb begin
      norm = raw_sum[MANT_WIDTH:0] << lz;
      if (carry) begin
         res_mant = raw_sum[MANT_WIDTH:1];                      // shift right, lsb to guard
         res_grs  = {raw_sum[0], {(GRS_WIDTH-1){1'b0}}};
         res_exp  = large_exp + 1'b1;
      end else begin
         res_mant = norm[MANT_WIDTH-1:0];
         res_grs  = '0;
         res_exp  = large_exp - EXP_WIDTH'(lz);
      end
   end

   always_comb begin
      flags = '0;
      if (a == DL_NAN || b == DL_NAN) begin
         sum = {DL_NAN, {GRS_WIDTH{1'b0}}};
      end else if (a == '0 && b == '0) begin
         sum = '0;
      end else if (large_exp == EXP_WIDTH'(EXP_MAX) && carry) begin
         sum            = {(res_sign ? DL_MAX_NEG : DL_MAX_POS), {GRS_WIDTH{1'b0}}};
         flags.overflow = 1'b1;
      end else if (!carry && large_exp >= 1 && large_exp <= 8 && lz > large_exp) begin
         // shift would push the exponent below one
         sum             = {(res_sign ? DL_MIN_NEG : DL_MIN_POS), {GRS_WIDTH{1'b0}}};
         flags.underflow = 1'b1;
      end else if (raw_sum == '0) begin
         sum = '0;                                           // exact cancellation
      end else if (res_exp == '0) begin
         sum             = '0;
         flags.underflow = 1'b1;
      end else begin
         sum = {res_sign, res_exp, res_mant, res_grs};
      end
      flags.inexact = (sum[GRS_WIDTH-1:0] != '0);
   end

endmodule

`default_nettype wire

/* src/dlfloat_mul.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_mul import dlfloat_pkg::*; (
   input  dl_float_t  a,
   input  dl_float_t  b,
   output dl_ext_t    product,
   output dl_flags_t  flags
);

   logic                              sign_p;
   logic [EXP_WIDTH:0]                exp_sum;   // one extra bit so 63+63 fits
   logic [EXP_WIDTH-1:0]              exp_prod;
   logic [2*MANT_WIDTH+1:0]           prod;
   logic                              prod_top;
   logic [MANT_WIDTH+GRS_WIDTH-1:0]   mant_ext;

   assign sign_p  = a[DL_WIDTH-1] ^ b[DL_WIDTH-1];
   assign exp_sum = {1'b0, a[DL_WIDTH-2 -: EXP_WIDTH]} + {1'b0, b[DL_WIDTH-2 -: EXP_WIDTH]};
   assign prod    = {1'b1, a[MANT_WIDTH-1:0]} * {1'b1, b[MANT_WIDTH-1:0]};
   assign prod_top = prod[2*MANT_WIDTH+1];

   // product in [1,4), normalize on the top bit
   assign mant_ext = prod_top ? prod[2*MANT_WIDTH -: MANT_WIDTH+GRS_WIDTH]
                              : prod[2*MANT_WIDTH-1 -: MANT_WIDTH+GRS_WIDTH];
   assign exp_prod = EXP_WIDTH'(exp_sum - EXP_BIAS + prod_top);

   always_comb begin
      flags = '0;
      if (a == DL_NAN || b == DL_NAN) begin
         product = {DL_NAN, {GRS_WIDTH{1'b0}}};
      end else if (a == '0 || b == '0) begin
         product = '0;
      end else if (exp_sum <= EXP_BIAS) begin
         product         = '0;                  // flush to zero
         flags.underflow = 1'b1;
      end else if (exp_sum > EXP_MAX + EXP_BIAS) begin
         product        = {(sign_p ? DL_MAX_NEG : DL_MAX_POS), {GRS_WIDTH{1'b0}}};
         flags.overflow = 1'b1;
      end else if (exp_sum == EXP_MAX + EXP_BIAS) begin
         // biased exponent would be all ones
         product       = {DL_NAN, {GRS_WIDTH{1'b0}}};
         flags.invalid = 1'b1;
      end else begin
         product = {sign_p, exp_prod, mant_ext};
      end
      flags.inexact = (product[GRS_WIDTH-1:0] != '0);
   end

endmodule

`default_nettype wire

/* src/dlfloat_sign_cmp.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_sign_cmp import dlfloat_pkg::*; (
   input  dl_float_t  a,
   input  dl_float_t  b,
   input  logic       is_cmp,
   input  sign_sel_t  sel_sign,
   input  cmp_sel_t   sel_cmp,
   output dl_ext_t    value,
   output dl_flags_t  flags
);

   logic      sign_a;
   logic      sign_b;
   logic      mag_gt;
   logic      mag_lt;
   logic      lt;
   logic      gt;
   logic      eq;
   dl_float_t res;

   assign sign_a = a[DL_WIDTH-1];
   assign sign_b = b[DL_WIDTH-1];
   // exponent above mantissa, so one compare covers both
   assign mag_gt = a[DL_WIDTH-2:0] > b[DL_WIDTH-2:0];
   assign mag_lt = a[DL_WIDTH-2:0] < b[DL_WIDTH-2:0];

   always_comb begin
      lt = 1'b0;
      gt = 1'b0;
      eq = 1'b0;
      if (sign_a != sign_b) begin
         lt = sign_a;
         gt = ~sign_a;
      end else if (mag_gt) begin
         gt = ~sign_a;                      // negative flips the order
         lt = sign_a;
      end else if (mag_lt) begin
         lt = ~sign_a;
         gt = sign_a;
      end else begin
         eq = 1'b1;
      end
   end

   always_comb begin
      flags = '0;
      res   = '0;
      if (is_cmp) begin
         case (sel_cmp)
            CMP_MIN: res = lt ? a : b;
            CMP_MAX: res = gt ? a : b;
            CMP_EQ:  res = {DL_WIDTH{eq}};
            CMP_LT:  res = {DL_WIDTH{lt}};
            CMP_LE:  res = {DL_WIDTH{lt | eq}};
            default: res = '0;
         endcase
         flags.underflow = (res == '0);
         flags.overflow  = (res == '1);
      end else begin
         // magnitude always from b
         case (sel_sign)
            SIGN_NEG: res = {~sign_a, b[DL_WIDTH-2:0]};
            SIGN_INJ: res = {sign_a, b[DL_WIDTH-2:0]};
            SIGN_INV: res = {~sign_a, b[DL_WIDTH-2:0]};
            SIGN_XOR: res = {sign_a ^ sign_b, b[DL_WIDTH-2:0]};
            default:  res = '0;
         endcase
      end
   end

   assign value = {res, {GRS_WIDTH{1'b0}}};

endmodule

`default_nettype wire

/* src/dlfloat_round.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_round import dlfloat_pkg::*; (
   input  dl_ext_t    value,
   input  rnd_mode_t  rm,
   output dl_float_t  rounded
);

   logic                  sign_in;
   logic [EXP_WIDTH-1:0]  exp_in;
   logic [MANT_WIDTH-1:0] mant_in;
   logic                  guard;
   logic                  rnd;
   logic                  sticky;
   logic                  any_grs;
   logic                  round_up;
   logic [MANT_WIDTH:0]   mant_inc;

   assign sign_in = value[EXT_WIDTH-1];
   assign exp_in  = value[EXT_WIDTH-2 -: EXP_WIDTH];
   assign mant_in = value[GRS_WIDTH +: MANT_WIDTH];
   assign guard   = value[3];
   assign rnd     = value[2];
   assign sticky  = value[1] | value[0];
   assign any_grs = guard | rnd | sticky;

   always_comb begin
      case (rm)
         // tie rounds up, above half only when lsb is set
         RM_NEAREST_EVEN: round_up = guard & (~(rnd | sticky) | mant_in[0]);
         RM_TO_ZERO:      round_up = 1'b0;
         RM_UP:           round_up = any_grs & ~sign_in;
         RM_DOWN:         round_up = any_grs & sign_in;
         default:         round_up = 1'b0;           // plain truncation
      endcase
   end

   assign mant_inc = {1'b0, mant_in} + (MANT_WIDTH+1)'(round_up);

   // carry out of the mantissa bumps the exponent
   assign rounded = {sign_in, exp_in + mant_inc[MANT_WIDTH], mant_inc[MANT_WIDTH-1:0]};

endmodule

`default_nettype wire

/* src/dlfloat_exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_exec_unit import dlfloat_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       in_valid,
   input  op_code_t   ena,
   input  logic       op,
   input  sign_sel_t  sel_sign,
   input  cmp_sel_t   sel_cmp,
   input  rnd_mode_t  rm,
   input  dl_float_t  op1,
   input  dl_float_t  op2,
   output logic       out_valid,
   output dl_float_t  result,
   output logic       invalid,
   output logic       inexact,
   output logic       overflow,
   output logic       underflow,
   output logic       div_by_zero
);

   // stage 1
   logic      s1_valid;
   op_code_t  s1_ena;
   logic      s1_op;
   sign_sel_t s1_sel_sign;
   cmp_sel_t  s1_sel_cmp;
   rnd_mode_t s1_rm;
   dl_float_t s1_a;
   dl_float_t s1_b;

   dl_ext_t   add_val;
   dl_ext_t   mul_val;
   dl_ext_t   sc_val;
   dl_flags_t add_flags;
   dl_flags_t mul_flags;
   dl_flags_t sc_flags;
   dl_ext_t   sel_val;
   dl_flags_t sel_flags;
   dl_float_t rounded;
   dl_flags_t flags_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
         s1_ena   <= '0;
      end else begin
         s1_valid <= in_valid;
         if (in_valid)
            s1_ena <= ena;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         s1_op       <= op;
         s1_sel_sign <= sel_sign;
         s1_sel_cmp  <= sel_cmp;
         s1_rm       <= rm;
         s1_a        <= op1;
         s1_b        <= op2;
      end
   end

   dlfloat_add_sub add_sub_inst (
      .a     (s1_a),
      .b     (s1_b),
      .op    (s1_op),
      .sum   (add_val),
      .flags (add_flags)
   );

   dlfloat_mul mul_inst (
      .a       (s1_a),
      .b       (s1_b),
      .product (mul_val),
      .flags   (mul_flags)
   );

   dlfloat_sign_cmp sign_cmp_inst (
      .a        (s1_a),
      .b        (s1_b),
      .is_cmp   (s1_ena == OP_CMP),
      .sel_sign (s1_sel_sign),
      .sel_cmp  (s1_sel_cmp),
      .value    (sc_val),
      .flags    (sc_flags)
   );

   always_comb begin
      case (s1_ena)
         OP_ADD_SUB: begin
            sel_val   = add_val;
            sel_flags = add_flags;
         end
         OP_MUL: begin
            sel_val   = mul_val;
            sel_flags = mul_flags;
         end
         OP_SIGN, OP_CMP: begin
            sel_val   = sc_val;
            sel_flags = sc_flags;
         end
         default: begin                      // unused codes give zero
            sel_val   = '0;
            sel_flags = '0;
         end
      endcase
   end

   dlfloat_round round_inst (
      .value   (sel_val),
      .rm      (s1_rm),
      .rounded (rounded)
   );

   // stage 2, holds last result while idle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
         result    <= '0;
         flags_q   <= '0;
      end else begin
         out_valid <= s1_valid;
         if (s1_valid) begin
            result  <= rounded;
            flags_q <= sel_flags;
         end
      end
   end

   assign invalid     = flags_q.invalid;
   assign inexact     = flags_q.inexact;
   assign overflow    = flags_q.overflow;
   assign underflow   = flags_q.underflow;
   assign div_by_zero = flags_q.div_by_zero;   // no unit raises it

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD     = 10,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      #(PERIOD*RST_CYCLES) arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* testbench/dlfloat_exec_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dlfloat_exec_unit_tb import dlfloat_pkg::*; ();

   localparam int CLK_PERIOD = 10;
   localparam int N_SIGN     = 200;
   localparam int N_CMP      = 240;
   localparam int N_ARITH    = 40;                  // per rounding mode
   localparam int N_DIRECTED = 13;
   localparam int N_UNUSED   = 20;
   localparam int N_BURST    = 50;
   localparam int TOTAL_OPS  = N_SIGN + N_CMP + 12*N_ARITH + 4*N_DIRECTED + N_UNUSED + N_BURST;
   // at most two cycles per op plus drain time
   localparam int TIMEOUT_NS = (2*TOTAL_OPS + 100) * CLK_PERIOD;

   logic      clk;
   logic      arst_n;
   logic      in_valid;
   op_code_t  ena;
   logic      op;
   sign_sel_t sel_sign;
   cmp_sel_t  sel_cmp;
   rnd_mode_t rm;
   dl_float_t op1;
   dl_float_t op2;
   logic      out_valid;
   dl_float_t result;
   logic      invalid;
   logic      inexact;
   logic      overflow;
   logic      underflow;
   logic      div_by_zero;

   integer      seed;
   logic [20:0] exp_q [$];                         // {result, flags} per issued op
   logic [20:0] expd;
   logic [20:0] last_out = '0;
   logic        iv_d1 = 1'b0;
   logic        iv_d2 = 1'b0;
   string       test_name = "reset";
   int          test_ops = 0;
   int          test_errors = 0;
   int          ops = 0;
   int          results = 0;
   int          checks = 0;
   int          errors = 0;

   tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) clock_gen_inst (
      .clk    (clk),
      .arst_n (arst_n)
   );

   dlfloat_exec_unit dlfloat_exec_unit_inst (
      .clk         (clk),
      .arst_n      (arst_n),
      .in_valid    (in_valid),
      .ena         (ena),
      .op          (op),
      .sel_sign    (sel_sign),
      .sel_cmp     (sel_cmp),
      .rm          (rm),
      .op1         (op1),
      .op2         (op2),
      .out_valid   (out_valid),
      .result      (result),
      .invalid     (invalid),
      .inexact     (inexact),
      .overflow    (overflow),
      .underflow   (underflow),
      .div_by_zero (div_by_zero)
   );

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("ERROR %s (%s): expected %h, actual %h", test_name, what, expected, actual);
         errors++;
         test_errors++;
      end
   endtask

   function automatic logic [31:0] next_random();
      return $random(seed);
   endfunction

   function automatic dl_float_t random_any();
      logic [31:0] r;
      r = next_random();
      return r[15:0];
   endfunction

   function automatic dl_float_t random_normal();
      logic [31:0] r;
      r = next_random();
      return {r[31], 6'(1 + (r[21:16] % 62)), r[8:0]};  // exponent 1 to 62
   endfunction

   // exponent within two of a to reach cancellation
   function automatic dl_float_t random_near(input dl_float_t a);
      logic [31:0] r;
      int          e;
      r = next_random();
      e = int'(a[14:9]) + int'(r[18:16] % 5) - 2;
      if (e < 1)
         e = 1;
      if (e > 62)
         e = 62;
      return {r[31], 6'(e), r[8:0]};
   endfunction

   // model returns {invalid, inexact, overflow, underflow, div_by_zero, extended value}
   function automatic logic [24:0] model_add_sub(input dl_float_t a, input dl_float_t b,
                                                 input logic sub);
      logic        sa;
      logic        sb;
      logic        sign;
      logic [5:0]  ea;
      logic [5:0]  eb;
      logic [5:0]  el;
      logic [5:0]  er;
      logic [9:0]  ml;
      logic [9:0]  ms;
      logic [9:0]  hi;
      logic [9:0]  lo;
      logic [10:0] raw;
      logic [9:0]  shifted;
      logic [8:0]  mant;
      logic [3:0]  grs;
      int          lz;
      logic        ovf;
      logic        unf;
      logic [19:0] v;
      sa  = a[15];
      sb  = b[15] ^ sub;
      ea  = a[14:9];
      eb  = b[14:9];
      ovf = 1'b0;
      unf = 1'b0;
      if (ea > eb) begin
         el = ea;
         ml = {1'b1, a[8:0]};
         ms = {1'b1, b[8:0]} >> (ea - eb);
      end else begin
         el = eb;                                   // ties go to b
         ml = {1'b1, b[8:0]};
         ms = {1'b1, a[8:0]} >> (eb - ea);
      end
      if (ea == 0 || eb == 0)
         ms = 10'h200;
      if (sa == sb)
         sign = sa;
      else if (a[14:0] > b[14:0])
         sign = sa;
      else if (a[14:0] < b[14:0])
         sign = sb;
      else
         sign = 1'b0;
      hi = (ms > ml) ? ms : ml;
      lo = (ms > ml) ? ml : ms;
      if (ea == 0 || eb == 0)
         raw = {1'b0, hi};
      else if (sa != sb)
         raw = {1'b0, hi} - {1'b0, lo};
      else
         raw = {1'b0, hi} + {1'b0, lo};
      lz = 0;
      while (lz < 10 && !raw[9 - lz])
         lz++;
      if (lz == 10)
         lz = 0;
      if (a == DL_NAN || b == DL_NAN) begin
         v = {DL_NAN, 4'h0};
      end else if (a == 0 && b == 0) begin
         v = '0;
      end else if (el == 63 && raw[10]) begin
         v   = {(sign ? DL_MAX_NEG : DL_MAX_POS), 4'h0};
         ovf = 1'b1;
      end else if (!raw[10] && el >= 1 && el <= 8 && lz > el) begin
         v   = {(sign ? DL_MIN_NEG : DL_MIN_POS), 4'h0};
         unf = 1'b1;
      end else if (raw == 0) begin
         v = '0;
      end else begin
         if (raw[10]) begin
            er   = el + 6'd1;
            mant = raw[9:1];
            grs  = {raw[0], 3'b000};
         end else begin
            er      = el - 6'(lz);
            shifted = raw[9:0] << lz;
            mant    = shifted[8:0];
            grs     = 4'h0;
         end
         if (er == 0) begin
            v   = '0;
            unf = 1'b1;
         end else begin
            v = {sign, er, mant, grs};
         end
      end
      return {1'b0, (v[3:0] != 0), ovf, unf, 1'b0, v};
   endfunction

   function automatic logic [24:0] model_mul(input dl_float_t a, input dl_float_t b);
      int          esum;
      logic [19:0] prod;
      logic [12:0] m13;
      logic [5:0]  er;
      logic        inv;
      logic        ovf;
      logic        unf;
      logic [19:0] v;
      esum = a[14:9] + b[14:9];
      prod = {1'b1, a[8:0]} * {1'b1, b[8:0]};
      m13  = prod[19] ? prod[18:6] : prod[17:5];
      er   = 6'(esum - 31 + int'(prod[19]));
      inv  = 1'b0;
      ovf  = 1'b0;
      unf  = 1'b0;
      if (a == DL_NAN || b == DL_NAN) begin
         v = {DL_NAN, 4'h0};
      end else if (a == 0 || b == 0) begin
         v = '0;
      end else if (esum <= 31) begin
         v   = '0;
         unf = 1'b1;
      end else if (esum > 94) begin
         v   = {((a[15] ^ b[15]) ? DL_MAX_NEG : DL_MAX_POS), 4'h0};
         ovf = 1'b1;
      end else if (esum == 94) begin
         v   = {DL_NAN, 4'h0};
         inv = 1'b1;
      end else begin
         v = {a[15] ^ b[15], er, m13};
      end
      return {inv, (v[3:0] != 0), ovf, unf, 1'b0, v};
   endfunction

   // signed order on sign, exponent and mantissa
   function automatic logic less_than(input dl_float_t x, input dl_float_t y);
      if (x[15] != y[15])
         return x[15];
      else if (x[15])
         return x[14:0] > y[14:0];
      else
         return x[14:0] < y[14:0];
   endfunction

   function automatic logic [24:0] model_sign_cmp(input dl_float_t a, input dl_float_t b,
                                                  input logic is_cmp, input sign_sel_t ss,
                                                  input cmp_sel_t cs);
      logic      lt;
      logic      gt;
      logic      eq;
      dl_float_t r;
      logic      ovf;
      logic      unf;
      lt  = less_than(a, b);
      gt  = less_than(b, a);
      eq  = (a == b);
      ovf = 1'b0;
      unf = 1'b0;
      if (is_cmp) begin
         case (cs)
            CMP_MIN: r = lt ? a : b;
            CMP_MAX: r = gt ? a : b;
            CMP_EQ:  r = eq ? 16'hFFFF : 16'h0000;
            CMP_LT:  r = lt ? 16'hFFFF : 16'h0000;
            CMP_LE:  r = (lt || eq) ? 16'hFFFF : 16'h0000;
            default: r = 16'h0000;
         endcase
         unf = (r == 16'h0000);
         ovf = (r == 16'hFFFF);
      end else begin
         case (ss)
            SIGN_INJ: r = {a[15], b[14:0]};
            SIGN_XOR: r = {a[15] ^ b[15], b[14:0]};
            default:  r = {~a[15], b[14:0]};
         endcase
      end
      return {1'b0, 1'b0, ovf, unf, 1'b0, r, 4'h0};
   endfunction

   function automatic dl_float_t model_round(input logic [19:0] v, input rnd_mode_t m);
      logic       any;
      logic       up;
      logic [9:0] mi;
      logic [5:0] e;
      any = |v[3:0];
      case (m)
         RM_NEAREST_EVEN: up = v[3] && (!(|v[2:0]) || v[4]);
         RM_UP:           up = any && !v[19];
         RM_DOWN:         up = any && v[19];
         default:         up = 1'b0;
      endcase
      mi = {1'b0, v[12:4]} + 10'(up);
      e  = v[18:13] + 6'(mi[9]);
      return {v[19], e, mi[8:0]};
   endfunction

   function automatic logic [20:0] model_op(input op_code_t e, input logic o,
                                            input sign_sel_t ss, input cmp_sel_t cs,
                                            input rnd_mode_t m, input dl_float_t a,
                                            input dl_float_t b);
      logic [24:0] x;
      case (e)
         OP_ADD_SUB: x = model_add_sub(a, b, o);
         OP_MUL:     x = model_mul(a, b);
         OP_SIGN:    x = model_sign_cmp(a, b, 1'b0, ss, cs);
         OP_CMP:     x = model_sign_cmp(a, b, 1'b1, ss, cs);
         default:    x = '0;
      endcase
      return {model_round(x[19:0], m), x[24:20]};
   endfunction

   task automatic issue_op(input op_code_t e, input logic o, input sign_sel_t ss,
                           input cmp_sel_t cs, input rnd_mode_t m, input dl_float_t a,
                           input dl_float_t b);
      @(posedge clk);
      in_valid <= 1'b1;
      ena      <= e;
      op       <= o;
      sel_sign <= ss;
      sel_cmp  <= cs;
      rm       <= m;
      op1      <= a;
      op2      <= b;
      exp_q.push_back(model_op(e, o, ss, cs, m, a, b));
      ops++;
      test_ops++;
   endtask

   task automatic hold_idle();
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic maybe_gap();
      logic [31:0] r;
      r = next_random();
      if (r[1:0] == 2'b00)
         hold_idle();
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_ops    = 0;
      test_errors = 0;
   endtask

   task automatic finish_test();
      hold_idle();
      while (exp_q.size() != 0)
         @(negedge clk);
      repeat (2) @(negedge clk);
      $display("test %s: %0d ops, %0d errors", test_name, test_ops, test_errors);
   endtask

   task automatic run_directed(input rnd_mode_t m);
      issue_op(OP_ADD_SUB, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h7E00, 16'h7E00);  // overflow
      issue_op(OP_ADD_SUB, 1'b0, SIGN_NEG, CMP_MIN, m, 16'hFE00, 16'hFE00);
      issue_op(OP_ADD_SUB, 1'b1, SIGN_NEG, CMP_MIN, m, 16'h0A05, 16'h0A04);  // underflow
      issue_op(OP_ADD_SUB, 1'b0, SIGN_NEG, CMP_MIN, m, DL_NAN, 16'h3E00);
      issue_op(OP_ADD_SUB, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h0000, 16'h0000);
      issue_op(OP_ADD_SUB, 1'b1, SIGN_NEG, CMP_MIN, m, 16'h3E00, 16'h3E00);  // exact cancel
      issue_op(OP_ADD_SUB, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h0000, 16'h3E05);
      issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h7C00, 16'h7C00);
      issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h0200, 16'h0200);
      issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h5E00, 16'h5E00);      // exponent sum 94
      issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, m, DL_NAN, 16'h3E00);
      issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h0000, 16'h3E00);
      issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, m, 16'h3ED4, 16'h3ED4);      // rounding carry
   endtask

   // sampled on the falling edge where outputs are settled
   always @(negedge clk) begin
      if (!arst_n) begin
         iv_d1 = 1'b0;
         iv_d2 = 1'b0;
      end else begin
         check_value("out_valid timing", iv_d2, out_valid);
         if (out_valid) begin
            results++;
            if (exp_q.size() == 0) begin
               $display("%s: out_valid went high with no operation outstanding", test_name);
               errors++;
               test_errors++;
            end else begin
               expd = exp_q.pop_front();
               check_value("result", expd[20:5], result);
               check_value("flags", expd[4:0],
                           {invalid, inexact, overflow, underflow, div_by_zero});
            end
            last_out = {result, invalid, inexact, overflow, underflow, div_by_zero};
         end else begin
            check_value("idle hold", last_out,
                        {result, invalid, inexact, overflow, underflow, div_by_zero});
         end
         iv_d2 = iv_d1;
         iv_d1 = in_valid;
      end
   end

   initial begin
      dl_float_t   a;
      dl_float_t   b;
      logic [31:0] r;
      op_code_t    code;
      int          base;
      seed     = 32'h7339;
      in_valid = 1'b0;
      ena      = '0;
      op       = 1'b0;
      sel_sign = '0;
      sel_cmp  = '0;
      rm       = '0;
      op1      = '0;
      op2      = '0;

      start_test("reset");
      wait (arst_n === 1'b1);
      repeat (3) @(negedge clk);
      check_value("out_valid", 0, out_valid);
      check_value("result", 0, result);
      check_value("flags", 0, {invalid, inexact, overflow, underflow, div_by_zero});
      finish_test();

      start_test("sign_inject");
      for (int i = 0; i < N_SIGN; i++) begin
         r = next_random();
         issue_op(OP_SIGN, r[0], sign_sel_t'(i % 4), cmp_sel_t'(r[3:1]), rnd_mode_t'(r[6:4]),
                  random_any(), random_any());
         maybe_gap();
      end
      finish_test();

      start_test("compare");
      for (int i = 0; i < N_CMP; i++) begin
         a = random_any();
         r = next_random();
         case (r[1:0])
            2'b00:   b = a;                           // equal operands
            2'b01:   b = {~a[15], a[14:0]};
            default: b = random_any();
         endcase
         issue_op(OP_CMP, r[2], SIGN_NEG, cmp_sel_t'(r[5:3]), rnd_mode_t'(r[8:6]), a, b);
         maybe_gap();
      end
      finish_test();

      start_test("arith");
      for (int m = 0; m < 4; m++) begin
         for (int i = 0; i < N_ARITH; i++) begin
            a = random_normal();
            r = next_random();
            b = r[0] ? random_near(a) : random_normal();
            issue_op(OP_ADD_SUB, 1'b0, SIGN_NEG, CMP_MIN, rnd_mode_t'(m), a, b);
            issue_op(OP_ADD_SUB, 1'b1, SIGN_NEG, CMP_MIN, rnd_mode_t'(m), a, b);
            issue_op(OP_MUL, 1'b0, SIGN_NEG, CMP_MIN, rnd_mode_t'(m), a, random_normal());
            maybe_gap();
         end
         run_directed(rnd_mode_t'(m));
      end
      finish_test();

      start_test("unused_opcode");
      for (int i = 0; i < N_UNUSED; i++) begin
         do begin
            r    = next_random();
            code = r[3:0];
         end while (code inside {OP_ADD_SUB, OP_MUL, OP_SIGN, OP_CMP});
         issue_op(code, r[4], sign_sel_t'(r[6:5]), cmp_sel_t'(r[9:7]), rnd_mode_t'(r[12:10]),
                  random_any(), random_any());
         maybe_gap();
      end
      finish_test();

      start_test("burst");
      base = results;
      for (int i = 0; i < N_BURST; i++) begin
         r = next_random();
         case (r[2:0] % 5)
            0:       code = OP_ADD_SUB;
            1:       code = OP_MUL;
            2:       code = OP_SIGN;
            3:       code = OP_CMP;
            default: code = 4'b1111;
         endcase
         issue_op(code, r[3], sign_sel_t'(r[5:4]), cmp_sel_t'(r[8:6]), rnd_mode_t'(r[10:9]),
                  random_normal(), random_normal());
      end
      finish_test();
      check_value("burst result count", N_BURST, results - base);

      $display("summary: %0d operations, %0d checks, %0d errors", ops, checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: run still busy after %0d ns with %0d results outstanding",
               TIMEOUT_NS, exp_q.size());
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* dlfloat_exec_unit.f */
common/dlfloat_pkg.sv
add_sub/dlfloat_align.sv
add_sub/dlfloat_add_sub.sv
src/dlfloat_mul.sv
src/dlfloat_sign_cmp.sv
src/dlfloat_round.sv
src/dlfloat_exec_unit.sv
testbench/tb_clock_gen.sv
testbench/dlfloat_exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DLFloat16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module dlfloat_exec_unit_tb \
   -f dlfloat_exec_unit.f > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/Vdlfloat_exec_unit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -qx "Simulation passed" sim.log; then
   exit 0
fi
exit 1
